// File: logic/audio_mixer_top.sv
//////////////////////////////////////////////////
// Stereo mixer top: register file and mixer core
//////////////////////////////////////////////////

module audio_mixer_top (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  audio_pkg::audio_frame_t                 in_frame,
  input  logic                                    frame_valid,
  input  logic                                    reg_wr,
  input  logic                                    reg_rd,
  input  mix_regs_pkg::mix_reg_addr_e             reg_addr,
  input  logic [mix_regs_pkg::reg_data_width-1:0] reg_wdata,
  output logic [mix_regs_pkg::reg_data_width-1:0] reg_rdata,
  output logic                                    reg_rvalid,
  output audio_pkg::stereo_sample_t               out_sample,
  output logic                                    out_valid
);

  mix_regs_pkg::mix_ctrl_t ctrl;
  mix_regs_pkg::mix_clip_t clip;

  mixer_register_file u_regs (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .reg_wr     ( reg_wr     ),
    .reg_rd     ( reg_rd     ),
    .reg_addr   ( reg_addr   ),
    .reg_wdata  ( reg_wdata  ),
    .reg_rdata  ( reg_rdata  ),
    .reg_rvalid ( reg_rvalid ),
    .ctrl       ( ctrl       ),
    .clip       ( clip       )
  );

  mixer_core u_core (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .in_frame    ( in_frame    ),
    .frame_valid ( frame_valid ),
    .ctrl        ( ctrl        ),
    .out_sample  ( out_sample  ),
    .out_valid   ( out_valid   ),
    .clip        ( clip        )
  );

endmodule

// File: logic/audio_pkg.sv
//////////////////////////////////////////////////
// Audio sample format, channel count and the
// fixed-point gain format of the mixer
// Frame and stereo sample structs
//////////////////////////////////////////////////

package audio_pkg;

  // Sample and gain widths
  localparam int audio_width = 16;
  localparam int gain_width  = 16;

  // Gains are unsigned Q8, so 256 is unity
  localparam int q_bits = 8;

  localparam int nr_channels = 4;

  // Two guard bits cover the sum of four full-scale samples
  localparam int sum_width = audio_width + 2;

  // Saturation limits of a sample
  localparam logic signed [audio_width-1:0] sample_max = {1'b0, {(audio_width-1){1'b1}}};
  localparam logic signed [audio_width-1:0] sample_min = {1'b1, {(audio_width-1){1'b0}}};

  // One sample per input channel, channel 0 in the low bits
  typedef struct packed {
    logic [nr_channels-1:0][audio_width-1:0] ch;
  } audio_frame_t;

  typedef struct packed {
    logic signed [audio_width-1:0] left;
    logic signed [audio_width-1:0] right;
  } stereo_sample_t;

endpackage

// File: logic/fixed_point_multiplier.sv
//////////////////////////////////////////////////
// Signed sample times unsigned Q-format gain,
// registered, saturated to the sample range
//////////////////////////////////////////////////

module fixed_point_multiplier (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic signed [audio_pkg::audio_width-1:0] multiplicand,
  input  logic        [audio_pkg::gain_width-1:0]  multiplier,
  input  logic                                    valid_in,
  output logic signed [audio_pkg::audio_width-1:0] product,
  output logic                                    overflow,
  output logic                                    valid_out
);

  logic signed [audio_pkg::audio_width+audio_pkg::gain_width:0] full_product;
  logic signed [audio_pkg::audio_width+audio_pkg::gain_width:0] scaled;
  logic signed [audio_pkg::audio_width-1:0]                     result;
  logic                                                         saturated;

  always_comb begin
    // Gain is zero-extended so it stays positive
    full_product = multiplicand * $signed({1'b0, multiplier});
    // Arithmetic shift, rounds toward minus infinity
    scaled    = full_product >>> audio_pkg::q_bits;
    result    = scaled[audio_pkg::audio_width-1:0];
    saturated = 1'b0;
    if (scaled > audio_pkg::sample_max) begin
      result    = audio_pkg::sample_max;
      saturated = 1'b1;
    end else if (scaled < audio_pkg::sample_min) begin
      result    = audio_pkg::sample_min;
      saturated = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      valid_out <= valid_in;
      overflow  <= valid_in && saturated;
    end
  end

  // Result held between valid samples
  always_ff @(posedge clk) begin
    if (valid_in) begin
      product <= result;
    end
  end

endmodule

// File: logic/mix_regs_pkg.sv
//////////////////////////////////////////////////
// Register map of the mixer: address enum,
// control and clip structs, reset values
//////////////////////////////////////////////////

package mix_regs_pkg;

  localparam int reg_data_width = 16;

  // Output clip, channel clips, left and right sum clips
  localparam int status_width = audio_pkg::nr_channels + 3;

  // Unity gain
  localparam logic [audio_pkg::gain_width-1:0] gain_reset = 256;

  typedef enum logic [3:0] {
    reg_ch_gain_0 = 4'd0,
    reg_ch_gain_1 = 4'd1,
    reg_ch_gain_2 = 4'd2,
    reg_ch_gain_3 = 4'd3,
    reg_route     = 4'd4,
    reg_out_gain  = 4'd5,
    reg_status    = 4'd6
  } mix_reg_addr_e;

  typedef struct packed {
    logic [audio_pkg::nr_channels-1:0][audio_pkg::gain_width-1:0] ch_gain;
    logic [audio_pkg::nr_channels-1:0]                            route;
    logic [audio_pkg::gain_width-1:0]                             out_gain;
  } mix_ctrl_t;

  // One-cycle pulses, each in the cycle of its own stage
  typedef struct packed {
    logic [audio_pkg::nr_channels-1:0] channel;
    logic                              sum_left;
    logic                              sum_right;
    logic                              out;
  } mix_clip_t;

endpackage

// File: logic/mixer_channel.sv
//////////////////////////////////////////////////
// Single mixer channel: gain stage and routing
// of the gained sample to the left or right bus
//////////////////////////////////////////////////

module mixer_channel (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic signed [audio_pkg::audio_width-1:0] sample,
  input  logic                                    sample_valid,
  input  logic        [audio_pkg::gain_width-1:0]  gain,
  input  logic                                    route_right,
  output logic signed [audio_pkg::audio_width-1:0] left,
  output logic signed [audio_pkg::audio_width-1:0] right,
  output logic                                    out_valid,
  output logic                                    clip
);

  logic signed [audio_pkg::audio_width-1:0] gained;

  //////////////////////////////////////////////////
  // Gain stage
  //////////////////////////////////////////////////

  fixed_point_multiplier u_gain (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .multiplicand ( sample       ),
    .multiplier   ( gain         ),
    .valid_in     ( sample_valid ),
    .product      ( gained       ),
    .overflow     ( clip         ),
    .valid_out    ( out_valid    )
  );

  //////////////////////////////////////////////////
  // Routing
  //////////////////////////////////////////////////

  // Unused bus gets zero so the core can sum everything
  always_comb begin
    if (route_right) begin
      left  = '0;
      right = gained;
    end else begin
      left  = gained;
      right = '0;
    end
  end

endmodule

// File: logic/mixer_core.sv
//////////////////////////////////////////////////
// Mixer datapath: channel gain stages, saturating
// left and right bus sums, output gain stages
//////////////////////////////////////////////////

module mixer_core (
  input  logic                      clk,
  input  logic                      rst_n,
  input  audio_pkg::audio_frame_t   in_frame,
  input  logic                      frame_valid,
  input  mix_regs_pkg::mix_ctrl_t   ctrl,
  output audio_pkg::stereo_sample_t out_sample,
  output logic                      out_valid,
  output mix_regs_pkg::mix_clip_t   clip
);

  // Channel outputs, stage 1
  logic signed [audio_pkg::audio_width-1:0] ch_left  [audio_pkg::nr_channels];
  logic signed [audio_pkg::audio_width-1:0] ch_right [audio_pkg::nr_channels];
  logic        [audio_pkg::nr_channels-1:0] ch_valid;
  logic        [audio_pkg::nr_channels-1:0] ch_clip;

  // Bus sums, stage 2
  logic signed [audio_pkg::sum_width-1:0]   sum_left;
  logic signed [audio_pkg::sum_width-1:0]   sum_right;
  logic signed [audio_pkg::audio_width-1:0] sum_left_q;
  logic signed [audio_pkg::audio_width-1:0] sum_right_q;
  logic                                     sum_valid;
  logic                                     sum_clip_left;
  logic                                     sum_clip_right;

  // Output stage 3
  logic valid_left;
  logic valid_right;
  logic out_clip_left;
  logic out_clip_right;

  function automatic logic out_of_range(input logic signed [audio_pkg::sum_width-1:0] value);
    return (value > audio_pkg::sample_max) || (value < audio_pkg::sample_min);
  endfunction

  function automatic logic signed [audio_pkg::audio_width-1:0] clamp(
    input logic signed [audio_pkg::sum_width-1:0] value
  );
    if (value > audio_pkg::sample_max) begin
      return audio_pkg::sample_max;
    end else if (value < audio_pkg::sample_min) begin
      return audio_pkg::sample_min;
    end
    return value[audio_pkg::audio_width-1:0];
  endfunction

  //////////////////////////////////////////////////
  // Channel gain stages
  //////////////////////////////////////////////////

  for (genvar i = 0; i < audio_pkg::nr_channels; i++) begin : g_channel
    mixer_channel u_channel (
      .clk          ( clk                 ),
      .rst_n        ( rst_n               ),
      .sample       ( in_frame.ch[i]      ),
      .sample_valid ( frame_valid         ),
      .gain         ( ctrl.ch_gain[i]     ),
      .route_right  ( ctrl.route[i]       ),
      .left         ( ch_left[i]          ),
      .right        ( ch_right[i]         ),
      .out_valid    ( ch_valid[i]         ),
      .clip         ( ch_clip[i]          )
    );
  end

  //////////////////////////////////////////////////
  // Saturating bus sums
  //////////////////////////////////////////////////

  always_comb begin
    sum_left  = '0;
    sum_right = '0;
    for (int i = 0; i < audio_pkg::nr_channels; i++) begin
      sum_left  = sum_left + audio_pkg::sum_width'(ch_left[i]);
      sum_right = sum_right + audio_pkg::sum_width'(ch_right[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid      <= 1'b0;
      sum_clip_left  <= 1'b0;
      sum_clip_right <= 1'b0;
    end else begin
      // All channels share one valid, they run in lock step
      sum_valid      <= &ch_valid;
      sum_clip_left  <= (&ch_valid) && out_of_range(sum_left);
      sum_clip_right <= (&ch_valid) && out_of_range(sum_right);
    end
  end

  always_ff @(posedge clk) begin
    if (&ch_valid) begin
      sum_left_q  <= clamp(sum_left);
      sum_right_q <= clamp(sum_right);
    end
  end

  //////////////////////////////////////////////////
  // Output gain stages
  //////////////////////////////////////////////////

  fixed_point_multiplier u_out_gain_left (
    .clk          ( clk              ),
    .rst_n        ( rst_n            ),
    .multiplicand ( sum_left_q       ),
    .multiplier   ( ctrl.out_gain    ),
    .valid_in     ( sum_valid        ),
    .product      ( out_sample.left  ),
    .overflow     ( out_clip_left    ),
    .valid_out    ( valid_left       )
  );

  fixed_point_multiplier u_out_gain_right (
    .clk          ( clk              ),
    .rst_n        ( rst_n            ),
    .multiplicand ( sum_right_q      ),
    .multiplier   ( ctrl.out_gain    ),
    .valid_in     ( sum_valid        ),
    .product      ( out_sample.right ),
    .overflow     ( out_clip_right   ),
    .valid_out    ( valid_right      )
  );

  assign out_valid = valid_left & valid_right;

  // Each pulse is already aligned to its own stage
  assign clip.channel   = ch_clip;
  assign clip.sum_left  = sum_clip_left;
  assign clip.sum_right = sum_clip_right;
  assign clip.out       = out_clip_left | out_clip_right;

endmodule

// File: logic/mixer_register_file.sv
//////////////////////////////////////////////////
// Mixer registers: strobe writes and reads,
// control outputs, sticky clip status
//////////////////////////////////////////////////

module mixer_register_file (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    reg_wr,
  input  logic                                    reg_rd,
  input  mix_regs_pkg::mix_reg_addr_e             reg_addr,
  input  logic [mix_regs_pkg::reg_data_width-1:0] reg_wdata,
  output logic [mix_regs_pkg::reg_data_width-1:0] reg_rdata,
  output logic                                    reg_rvalid,
  output mix_regs_pkg::mix_ctrl_t                 ctrl,
  input  mix_regs_pkg::mix_clip_t                 clip
);

  logic [mix_regs_pkg::status_width-1:0]   status;
  logic [mix_regs_pkg::status_width-1:0]   clip_bits;
  logic [mix_regs_pkg::reg_data_width-1:0] read_mux;
  logic                                    status_read;

  // Bit 0 output, then channels, then left and right sums
  assign clip_bits   = {clip.sum_right, clip.sum_left, clip.channel, clip.out};
  assign status_read = reg_rd && (reg_addr == mix_regs_pkg::reg_status);

  //////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl.ch_gain  <= {audio_pkg::nr_channels{mix_regs_pkg::gain_reset}};
      ctrl.route    <= '0;
      ctrl.out_gain <= mix_regs_pkg::gain_reset;
    end else if (reg_wr) begin
      case (reg_addr)
        mix_regs_pkg::reg_ch_gain_0: ctrl.ch_gain[0] <= reg_wdata;
        mix_regs_pkg::reg_ch_gain_1: ctrl.ch_gain[1] <= reg_wdata;
        mix_regs_pkg::reg_ch_gain_2: ctrl.ch_gain[2] <= reg_wdata;
        mix_regs_pkg::reg_ch_gain_3: ctrl.ch_gain[3] <= reg_wdata;
        mix_regs_pkg::reg_route:     ctrl.route      <= reg_wdata[audio_pkg::nr_channels-1:0];
        mix_regs_pkg::reg_out_gain:  ctrl.out_gain   <= reg_wdata;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Sticky status and read path
  //////////////////////////////////////////////////

  // A pulse in the clearing cycle is kept
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status     <= '0;
      reg_rvalid <= 1'b0;
    end else begin
      status     <= status_read ? clip_bits : (status | clip_bits);
      reg_rvalid <= reg_rd;
    end
  end

  always_comb begin
    read_mux = '0;
    case (reg_addr)
      mix_regs_pkg::reg_ch_gain_0: read_mux = ctrl.ch_gain[0];
      mix_regs_pkg::reg_ch_gain_1: read_mux = ctrl.ch_gain[1];
      mix_regs_pkg::reg_ch_gain_2: read_mux = ctrl.ch_gain[2];
      mix_regs_pkg::reg_ch_gain_3: read_mux = ctrl.ch_gain[3];
      mix_regs_pkg::reg_route:     read_mux[audio_pkg::nr_channels-1:0] = ctrl.route;
      mix_regs_pkg::reg_out_gain:  read_mux = ctrl.out_gain;
      mix_regs_pkg::reg_status:    read_mux[mix_regs_pkg::status_width-1:0] = status;
      default:                     read_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reg_rd) begin
      reg_rdata <= read_mux;
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_audio_mixer \
  --Mdir obj_dir -o sim_audio_mixer > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_audio_mixer > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status, see sim.log"
  exit 1
fi

if grep -qx "TEST OK" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: src.f
logic/audio_pkg.sv
logic/mix_regs_pkg.sv
logic/fixed_point_multiplier.sv
logic/mixer_channel.sv
logic/mixer_core.sv
logic/mixer_register_file.sv
logic/audio_mixer_top.sv
test/tb_audio_mixer.sv

// File: test/tb_audio_mixer.sv
//////////////////////////////////////////////////
// Testbench for the stereo mixer with a stimulus
// table, reference model, register tasks and an
// output monitor
//////////////////////////////////////////////////

module tb_audio_mixer;

  typedef struct packed {
    mix_regs_pkg::mix_ctrl_t ctrl;
    audio_pkg::audio_frame_t frame;
    logic                    chain;
  } stim_t;

  typedef struct packed {
    audio_pkg::stereo_sample_t             sample;
    logic [mix_regs_pkg::status_width-1:0] clip;
  } model_t;

  typedef struct packed {
    audio_pkg::stereo_sample_t sample;
    logic [31:0]               sent;
  } pending_t;

  localparam int     nr_entries = 12;
  localparam longint smax       = longint'(audio_pkg::sample_max);
  localparam longint smin       = longint'(audio_pkg::sample_min);

  logic                                    clk;
  logic                                    rst_n;
  audio_pkg::audio_frame_t                 in_frame;
  logic                                    frame_valid;
  logic                                    reg_wr;
  logic                                    reg_rd;
  mix_regs_pkg::mix_reg_addr_e             reg_addr;
  logic [mix_regs_pkg::reg_data_width-1:0] reg_wdata;
  logic [mix_regs_pkg::reg_data_width-1:0] reg_rdata;
  logic                                    reg_rvalid;
  audio_pkg::stereo_sample_t               out_sample;
  logic                                    out_valid;

  stim_t                                 stim [nr_entries];
  pending_t                              pending_q [$];
  pending_t                              head;
  logic [mix_regs_pkg::status_width-1:0] exp_status;
  logic [15:0]                           rd_data;
  logic [15:0]                           rd_expected;
  int                                    errors;
  int                                    checks;
  int                                    cycle;
  int                                    seed;

  audio_mixer_top u_audio_mixer_top (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .in_frame    ( in_frame    ),
    .frame_valid ( frame_valid ),
    .reg_wr      ( reg_wr      ),
    .reg_rd      ( reg_rd      ),
    .reg_addr    ( reg_addr    ),
    .reg_wdata   ( reg_wdata   ),
    .reg_rdata   ( reg_rdata   ),
    .reg_rvalid  ( reg_rvalid  ),
    .out_sample  ( out_sample  ),
    .out_valid   ( out_valid   )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle <= 0;
    end else begin
      cycle <= cycle + 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Multiply, floor shift by the fraction bits, saturate
  function automatic longint scale(input longint value, input longint gain, output logic sat);
    longint p;
    p   = (value * gain) >>> audio_pkg::q_bits;
    sat = (p > smax) || (p < smin);
    return (p > smax) ? smax : ((p < smin) ? smin : p);
  endfunction

  function automatic model_t mix_model(input mix_regs_pkg::mix_ctrl_t c,
                                       input audio_pkg::audio_frame_t f);
    model_t r;
    longint bus [2];
    longint gained;
    logic   sat;
    r      = '0;
    bus[0] = 0;
    bus[1] = 0;
    for (int i = 0; i < audio_pkg::nr_channels; i++) begin
      gained      = scale(longint'($signed(f.ch[i])), longint'(c.ch_gain[i]), sat);
      r.clip[i+1] = sat;
      if (c.route[i]) begin
        bus[1] += gained;
      end else begin
        bus[0] += gained;
      end
    end
    // Left sum clip goes to bit 5 and right to bit 6
    for (int b = 0; b < 2; b++) begin
      if (bus[b] > smax || bus[b] < smin) begin
        r.clip[5+b] = 1'b1;
        bus[b] = (bus[b] > smax) ? smax : smin;
      end
    end
    r.sample.left  = 16'(scale(bus[0], longint'(c.out_gain), sat));
    r.clip[0]      = sat;
    r.sample.right = 16'(scale(bus[1], longint'(c.out_gain), sat));
    r.clip[0]      = r.clip[0] | sat;
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Register and stream tasks
  //////////////////////////////////////////////////

  task automatic reg_write(input mix_regs_pkg::mix_reg_addr_e addr, input logic [15:0] data);
    reg_addr  = addr;
    reg_wdata = data;
    reg_wr    = 1'b1;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(input mix_regs_pkg::mix_reg_addr_e addr, output logic [15:0] data);
    int waited;
    waited   = 0;
    reg_addr = addr;
    reg_rd   = 1'b1;
    @(negedge clk);
    reg_rd = 1'b0;
    while (!reg_rvalid && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    data = reg_rdata;
    if (!reg_rvalid) begin
      $display("Timeout: no reg_rvalid after a read of address %0d", addr);
      errors++;
    end else begin
      check_value("reg_rvalid delay", waited, 0);
    end
    // Read valid is a single-cycle strobe
    @(negedge clk);
    check_value("reg_rvalid", reg_rvalid, 0);
  endtask

  task automatic write_ctrl(input mix_regs_pkg::mix_ctrl_t c);
    reg_write(mix_regs_pkg::reg_ch_gain_0, c.ch_gain[0]);
    reg_write(mix_regs_pkg::reg_ch_gain_1, c.ch_gain[1]);
    reg_write(mix_regs_pkg::reg_ch_gain_2, c.ch_gain[2]);
    reg_write(mix_regs_pkg::reg_ch_gain_3, c.ch_gain[3]);
    reg_write(mix_regs_pkg::reg_route, 16'(c.route));
    reg_write(mix_regs_pkg::reg_out_gain, c.out_gain);
  endtask

  task automatic send_frame(input stim_t s);
    model_t m;
    m           = mix_model(s.ctrl, s.frame);
    in_frame    = s.frame;
    frame_valid = 1'b1;
    pending_q.push_back(pending_t'{sample: m.sample, sent: cycle});
    exp_status = exp_status | m.clip;
    @(negedge clk);
    frame_valid = 1'b0;
  endtask

  // Polls on the rising edge while the monitor pops on the falling edge
  task automatic wait_outputs();
    int waited;
    waited = 0;
    while (pending_q.size() != 0 && waited < 10) begin
      @(posedge clk);
      waited++;
    end
    if (pending_q.size() != 0) begin
      $display("Timeout: out_valid never came for %0d frames", pending_q.size());
      errors++;
      pending_q.delete();
    end
    @(negedge clk);
  endtask

  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (pending_q.size() == 0) begin
        $display("Error: out_valid went high with no frame in flight");
        errors++;
      end else begin
        head = pending_q.pop_front();
        check_value("out_sample.left", out_sample.left, head.sample.left);
        check_value("out_sample.right", out_sample.right, head.sample.right);
        check_value("out_valid latency", cycle - head.sent, 3);
      end
    end
  end

  function automatic mix_regs_pkg::mix_ctrl_t make_ctrl(input logic [15:0] g0, g1, g2, g3,
                                                       input logic [3:0] route,
                                                       input logic [15:0] out_gain);
    mix_regs_pkg::mix_ctrl_t c;
    c.ch_gain  = {g3, g2, g1, g0};
    c.route    = route;
    c.out_gain = out_gain;
    return c;
  endfunction

  function automatic audio_pkg::audio_frame_t make_frame(input logic signed [15:0] s0, s1,
                                                         s2, s3);
    audio_pkg::audio_frame_t f;
    f.ch = {s3, s2, s1, s0};
    return f;
  endfunction

  task automatic build_table();
    stim[0] = '{make_ctrl(256, 256, 256, 256, 4'h0, 256), make_frame(1000, -2000, 3000, 12345), 0};
    stim[1] = '{make_ctrl(256, 256, 256, 256, 4'h0, 256), make_frame(20000, 20000, -5000, 1000), 0};
    // Random gains up to about 2.0
    // Entries 6 to 8 follow entry 5 back to back
    for (int i = 2; i < 9; i++) begin
      stim[i].chain = (i > 5);
      if (i > 5) begin
        stim[i].ctrl = stim[i-1].ctrl;
      end else begin
        for (int k = 0; k < 4; k++) begin
          stim[i].ctrl.ch_gain[k] = 16'($random(seed)) & 16'h01ff;
        end
        stim[i].ctrl.route    = 4'($random(seed));
        stim[i].ctrl.out_gain = 16'($random(seed)) & 16'h01ff;
      end
      for (int k = 0; k < 4; k++) begin
        stim[i].frame.ch[k] = 16'($random(seed));
      end
    end
    // Extremes for channel, sum and output clipping
    stim[9]  = '{make_ctrl(16'hffff, 16'hffff, 16'hffff, 16'hffff, 4'b0101, 16'h0400),
                 make_frame(32767, -32768, 100, -100), 0};
    stim[10] = '{make_ctrl(256, 256, 256, 256, 4'h0, 16'h0400), make_frame(10000, 0, 0, 0), 0};
    stim[11] = '{make_ctrl(256, 256, 256, 256, 4'b1100, 128),
                 make_frame(-30000, -30000, 30000, 30000), 0};
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n       = 1'b0;
    in_frame    = '0;
    frame_valid = 1'b0;
    reg_wr      = 1'b0;
    reg_rd      = 1'b0;
    reg_addr    = mix_regs_pkg::reg_ch_gain_0;
    reg_wdata   = '0;
    errors      = 0;
    checks      = 0;
    seed        = 847;
    exp_status  = '0;
    build_table();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    check_value("out_valid", out_valid, 0);
    check_value("reg_rvalid", reg_rvalid, 0);

    // Reset values of every register
    for (int a = 0; a < 7; a++) begin
      reg_read(mix_regs_pkg::mix_reg_addr_e'(4'(a)), rd_data);
      rd_expected = (a == 4 || a == 6) ? 16'd0 : mix_regs_pkg::gain_reset;
      check_value($sformatf("reg_rdata[%0d]", a), rd_data, rd_expected);
    end

    for (int i = 0; i < nr_entries; i++) begin
      if (!stim[i].chain) begin
        write_ctrl(stim[i].ctrl);
      end
      send_frame(stim[i]);
      if (i == nr_entries - 1 || !stim[(i + 1) % nr_entries].chain) begin
        wait_outputs();
        reg_read(mix_regs_pkg::reg_status, rd_data);
        check_value("reg_rdata status", rd_data, 16'(exp_status));
        exp_status = '0;
      end
    end

    // Status was cleared by the last read
    reg_read(mix_regs_pkg::reg_status, rd_data);
    check_value("reg_rdata status after clear", rd_data, 0);

    // Unmapped addresses read zero, each after a nonzero read
    reg_read(mix_regs_pkg::reg_route, rd_data);
    check_value("reg_rdata route", rd_data, 16'(stim[nr_entries-1].ctrl.route));
    reg_read(mix_regs_pkg::mix_reg_addr_e'(4'd9), rd_data);
    check_value("reg_rdata unmapped 9", rd_data, 0);
    reg_read(mix_regs_pkg::reg_out_gain, rd_data);
    check_value("reg_rdata out_gain", rd_data, stim[nr_entries-1].ctrl.out_gain);
    reg_read(mix_regs_pkg::mix_reg_addr_e'(4'd15), rd_data);
    check_value("reg_rdata unmapped 15", rd_data, 0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
